// ==== denseLayer.f ====
nnPkg.sv
weightBank.sv
neuron.sv
winnerSelect.sv
denseLayer.sv
tbClock.sv
denseLayer_assert.sv
denseLayerTb.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module denseLayerTb -f denseLayer.f || exit 1
simOut="$(./obj_dir/VdenseLayerTb)"
echo "$simOut"
echo "$simOut" | grep -qx "Everything OK" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== denseLayerTb.sv ====
`timescale 1ns/10ps

module denseLayerTb
	import nnPkg::*;
();

	logic clk;
	logic reset;
	actVec activations;
	cfgOpT cfgOp;
	neuronIdx cfgNeuron;
	inputIdx cfgIndex;
	word cfgData;
	layerVec neuronOut;
	neuronIdx winner;
	word winnerValue;

	word modelWeights [numNeurons][numInputs]; // Copy of every weight written
	word modelBiases [numNeurons];
	integer seed;
	int wordErrors;
	int indexErrors;
	int otherErrors;

	tbClock clockGen
	(
		.clk(clk),
		.reset(reset)
	);

	denseLayer UUT
	(
		.clk(clk),
		.reset(reset),
		.activations(activations),
		.cfgOp(cfgOp),
		.cfgNeuron(cfgNeuron),
		.cfgIndex(cfgIndex),
		.cfgData(cfgData),
		.neuronOut(neuronOut),
		.winner(winner),
		.winnerValue(winnerValue)
	);

	bind denseLayer denseLayerAssert assertInst
	(
		.clk(clk),
		.reset(reset),
		.neuronOut(neuronOut),
		.winnerValue(winnerValue)
	);

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic word expectNeuron(int n, actVec acts);
		int acc;
		word sum16;
		acc = int'(modelBiases[n]);
		for (int i = 0; i < numInputs; i++)
		begin
			acc = acc + int'(acts[i]) * int'(modelWeights[n][i]); // Low 16 bits survive the wrap
		end
		sum16 = word'(acc);
		return sum16[wordWidth-1] ? '0 : sum16;
	endfunction

	function automatic layerVec expectLayer(actVec acts);
		layerVec outs;
		for (int n = 0; n < numNeurons; n++)
		begin
			outs[n] = expectNeuron(n, acts);
		end
		return outs;
	endfunction

	function automatic neuronIdx expectWinner(layerVec outs);
		neuronIdx best;
		best = '0;
		for (int n = 1; n < numNeurons; n++)
		begin
			if (outs[n] > outs[best])
			begin
				best = neuronIdx'(n); // Ties keep the lower index
			end
		end
		return best;
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic checkWord(string testName, word expected, word actual);
		if (actual !== expected)
		begin
			wordErrors++;
			$display("ERR %s expected %h actual %h", testName, expected, actual);
		end
	endtask

	task automatic checkIndex(string testName, neuronIdx expected, neuronIdx actual);
		if (actual !== expected)
		begin
			indexErrors++;
			$display("ERR %s expected %0d actual %0d", testName, expected, actual);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Configuration and stimulus
	////////////////////////////////////////////////////////////

	task automatic writeWeight(neuronIdx n, inputIdx i, word value);
		@(negedge clk);
		cfgOp = cfgWeight;
		cfgNeuron = n;
		cfgIndex = i;
		cfgData = value;
		if (i < inputIdx'(numInputs))
		begin
			modelWeights[n][i] = value;
		end
		@(negedge clk);
		cfgOp = cfgNone;
	endtask

	task automatic writeBias(neuronIdx n, word value);
		@(negedge clk);
		cfgOp = cfgBias;
		cfgNeuron = n;
		cfgData = value;
		modelBiases[n] = value;
		@(negedge clk);
		cfgOp = cfgNone;
	endtask

	task automatic setBiases(layerVec values);
		for (int n = 0; n < numNeurons; n++)
		begin
			writeBias(neuronIdx'(n), values[n]);
		end
	endtask

	task automatic clearConfig();
		@(negedge clk);
		cfgOp = cfgClear;
		for (int n = 0; n < numNeurons; n++)
		begin
			modelBiases[n] = '0;
			for (int i = 0; i < numInputs; i++)
			begin
				modelWeights[n][i] = '0;
			end
		end
		@(negedge clk);
		cfgOp = cfgNone;
	endtask

	task automatic applyAndCheck(string testName, actVec acts);
		layerVec expOut;
		neuronIdx expWin;
		@(negedge clk);
		activations = acts;
		expOut = expectLayer(acts);
		expWin = expectWinner(expOut);
		repeat (3) @(negedge clk); // Neuron latency
		for (int n = 0; n < numNeurons; n++)
		begin
			checkWord($sformatf("%s out%0d", testName, n), expOut[n], neuronOut[n]);
		end
		@(negedge clk); // One more edge for the winner
		checkIndex($sformatf("%s winner", testName), expWin, winner);
		checkWord($sformatf("%s winnerValue", testName), expOut[expWin], winnerValue);
	endtask

	task automatic randomActs(output actVec acts);
		for (int i = 0; i < numInputs; i++)
		begin
			acts[i] = word'($random(seed));
		end
	endtask

	task automatic waitForReset();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (reset !== 1'b0 && cycles < 20)
		begin
			@(negedge clk);
			cycles++;
		end
		if (reset !== 1'b0)
		begin
			otherErrors++;
			$display("Reset was never released within 20 cycles");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic testReset();
		actVec acts;
		for (int n = 0; n < numNeurons; n++)
		begin
			checkWord("reset out", '0, neuronOut[n]);
		end
		checkIndex("reset winner", '0, winner);
		checkWord("reset winnerValue", '0, winnerValue);
		randomActs(acts);
		applyAndCheck("zeroWeights", acts);
	endtask

	task automatic testPassThrough();
		actVec acts;
		clearConfig();
		for (int n = 0; n < numNeurons; n++)
		begin
			writeWeight(neuronIdx'(n), inputIdx'(3 * n + 2), 16'sd1); // Indices 2, 5, 8, 11
		end
		for (int i = 0; i < numInputs; i++)
		begin
			acts[i] = word'(100 + 37 * i);
		end
		applyAndCheck("passThrough", acts);
		checkWord("passThrough literal", acts[8], neuronOut[2]);
		acts[8] = -16'sd50; // Neuron 2 sees a negative sum
		applyAndCheck("reluNegative", acts);
		checkWord("reluNegative literal", '0, neuronOut[2]);
	endtask

	task automatic testStream();
		actVec acts;
		layerVec expHist [40];
		neuronIdx expWin;
		clearConfig();
		for (int n = 0; n < numNeurons; n++)
		begin
			for (int i = 0; i < numInputs; i++)
			begin
				writeWeight(neuronIdx'(n), inputIdx'(i), word'($random(seed)));
			end
			writeBias(neuronIdx'(n), word'($random(seed)));
		end
		// New vector every cycle with up to three in flight
		for (int t = 0; t < 44; t++)
		begin
			@(negedge clk);
			if (t >= 3 && t < 43)
			begin
				for (int n = 0; n < numNeurons; n++)
				begin
					checkWord($sformatf("stream%0d out%0d", t - 3, n), expHist[t-3][n],
						neuronOut[n]);
				end
			end
			if (t >= 4)
			begin
				expWin = expectWinner(expHist[t-4]);
				checkIndex($sformatf("stream%0d winner", t - 4), expWin, winner);
				checkWord($sformatf("stream%0d winnerValue", t - 4), expHist[t-4][expWin],
					winnerValue);
			end
			if (t < 40)
			begin
				randomActs(acts);
				activations = acts;
				expHist[t] = expectLayer(acts);
			end
		end
	endtask

	task automatic testBias();
		actVec acts;
		clearConfig();
		setBiases({word'(16'h8000), 16'sd32767, -16'sd5, 16'sd1234}); // Index 3 first
		randomActs(acts);
		applyAndCheck("biasOnly", acts);
		checkWord("biasOnly literal0", 16'sd1234, neuronOut[0]);
		checkWord("biasOnly literal1", '0, neuronOut[1]);
		writeWeight(2'd0, 4'd15, 16'sd5); // Out of range
		applyAndCheck("index15", acts);
		checkWord("index15 literal", 16'sd1234, neuronOut[0]);
		clearConfig();
		applyAndCheck("afterClear", acts);
	endtask

	task automatic testWinner();
		actVec acts;
		acts = '0;
		clearConfig();
		setBiases({16'sd40, 16'sd20, 16'sd300, 16'sd10});
		applyAndCheck("distinct", acts);
		checkIndex("distinct literal", 2'd1, winner);
		setBiases({16'sd90, 16'sd90, 16'sd90, 16'sd5});
		applyAndCheck("tie", acts);
		checkIndex("tie literal", 2'd1, winner);
		setBiases({16'sd33, 16'sd33, 16'sd33, 16'sd33});
		applyAndCheck("allEqual", acts);
		checkIndex("allEqual literal", 2'd0, winner);
		clearConfig();
		applyAndCheck("allZero", acts);
		checkIndex("allZero literal", 2'd0, winner);
		checkWord("allZero value", '0, winnerValue);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		seed = 62926;
		wordErrors = 0;
		indexErrors = 0;
		otherErrors = 0;
		activations = '0;
		cfgOp = cfgNone;
		cfgNeuron = '0;
		cfgIndex = '0;
		cfgData = '0;
		for (int n = 0; n < numNeurons; n++)
		begin
			modelBiases[n] = '0;
			for (int i = 0; i < numInputs; i++)
			begin
				modelWeights[n][i] = '0;
			end
		end
		waitForReset();
		if (otherErrors == 0)
		begin
			testReset();
			testPassThrough();
			testStream();
			testBias();
			testWinner();
		end
		otherErrors += UUT.assertInst.failCount; // Failed concurrent assertions
		$display("Errors: word %0d, index %0d, other %0d", wordErrors, indexErrors, otherErrors);
		if (wordErrors + indexErrors + otherErrors == 0)
		begin
			$display("Everything OK");
		end
		else
		begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== denseLayer_assert.sv ====
`timescale 1ns/10ps

module denseLayerAssert
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input layerVec neuronOut,
	input word winnerValue
);

	int failCount = 0; // Read by the testbench at the end of the run

	////////////////////////////////////////////////////////////
	// Per-neuron properties
	////////////////////////////////////////////////////////////

	for (genvar n = 0; n < numNeurons; n++)
	begin : sliceGen
		// ReLU output is never negative
		reluNonNegative: assert property (@(posedge clk) disable iff (reset)
			neuronOut[n][wordWidth-1] == 1'b0)
			else
			begin
				failCount++;
				$error("neuronOut slice %0d has its sign bit set", n);
			end

		// Winner value covers every score of the cycle before
		winnerIsMax: assert property (@(posedge clk) disable iff (reset)
			winnerValue >= $past(neuronOut[n]))
			else
			begin
				failCount++;
				$error("winnerValue is below neuronOut slice %0d", n);
			end
	end

	////////////////////////////////////////////////////////////
	// Reset
	////////////////////////////////////////////////////////////

	resetClears: assert property (@(posedge clk)
		$past(reset) |-> (neuronOut == '0 && winnerValue == '0))
		else
		begin
			failCount++;
			$error("outputs not zero in the cycle after reset");
		end

endmodule

// ==== tbClock.sv ====
`timescale 1ns/10ps

module tbClock
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#50 clk = ~clk; // 100 ns period
		end
	end

	initial
	begin
		reset = 1'b1;
		repeat (5) @(posedge clk); // Five reset cycles
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== denseLayer.sv ====
`timescale 1ns/10ps

module denseLayer
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input actVec activations,
	input cfgOpT cfgOp,
	input neuronIdx cfgNeuron,
	input inputIdx cfgIndex,
	input word cfgData,
	output layerVec neuronOut,
	output neuronIdx winner,
	output word winnerValue
);

	weightMat weights;
	layerVec biases;

	////////////////////////////////////////////////////////////
	// Configuration storage
	////////////////////////////////////////////////////////////

	weightBank bankInst
	(
		.clk(clk),
		.reset(reset),
		.cfgOp(cfgOp),
		.cfgNeuron(cfgNeuron),
		.cfgIndex(cfgIndex),
		.cfgData(cfgData),
		.weights(weights),
		.biases(biases)
	);

	////////////////////////////////////////////////////////////
	// Neurons
	////////////////////////////////////////////////////////////

	// All neurons see the same activation vector
	for (genvar n = 0; n < numNeurons; n++)
	begin : neuronGen
		neuron neuronInst
		(
			.clk(clk),
			.reset(reset),
			.activations(activations),
			.weights(weights[n]),
			.bias(biases[n]),
			.result(neuronOut[n])
		);
	end

	////////////////////////////////////////////////////////////
	// Winner
	////////////////////////////////////////////////////////////

	winnerSelect selectInst
	(
		.clk(clk),
		.reset(reset),
		.scores(neuronOut),
		.winner(winner),
		.winnerValue(winnerValue)
	);

endmodule

// ==== winnerSelect.sv ====
`timescale 1ns/10ps

module winnerSelect
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input layerVec scores,
	output neuronIdx winner,
	output word winnerValue
);

	neuronIdx bestIdx;
	word bestValue;

	////////////////////////////////////////////////////////////
	// Argmax
	////////////////////////////////////////////////////////////

	// Scan from index 0 upward; a later score must be strictly larger
	// to take over, so ties stay with the lowest index
	always_comb
	begin
		bestIdx = '0;
		bestValue = scores[0];
		for (int i = 1; i < numNeurons; i++)
		begin
			if (scores[i] > bestValue)
			begin
				bestIdx = neuronIdx'(i);
				bestValue = scores[i];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Output registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			winner <= '0;
			winnerValue <= '0;
		end
		else
		begin
			winner <= bestIdx;         // One edge after neuronOut
			winnerValue <= bestValue;
		end
	end

endmodule

// ==== neuron.sv ====
`timescale 1ns/10ps

module neuron
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input actVec activations,
	input actVec weights,
	input word bias,
	output word result
);

	actVec actReg;              // Stage 1
	word products [numInputs];  // Truncated products
	word sumNext;
	word sumReg;                // Stage 2
	word reluOut;

	////////////////////////////////////////////////////////////
	// Stage 1: activation register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
		end
		else
		begin
			actReg <= activations;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 2: truncating multiply and wraparound sum
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < numInputs; i++)
	begin : mulGen
		product fullProd;

		assign fullProd = $signed(actReg[i]) * $signed(weights[i]);
		assign products[i] = fullProd[wordWidth-1:0]; // Keep low 16 bits only
	end

	// Accumulator is a word, so every add wraps modulo 2^16
	always_comb
	begin
		sumNext = bias;
		for (int i = 0; i < numInputs; i++)
		begin
			sumNext = sumNext + products[i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= sumNext;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 3: ReLU output register
	////////////////////////////////////////////////////////////

	// Negative sum clamps to zero
	assign reluOut = sumReg[wordWidth-1] ? '0 : sumReg;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else
		begin
			result <= reluOut;
		end
	end

endmodule

// ==== weightBank.sv ====
`timescale 1ns/10ps

module weightBank
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input cfgOpT cfgOp,
	input neuronIdx cfgNeuron,
	input inputIdx cfgIndex,
	input word cfgData,
	output weightMat weights,
	output layerVec biases
);

	////////////////////////////////////////////////////////////
	// Opcode decode
	////////////////////////////////////////////////////////////

	logic indexValid;
	logic weightWe;
	logic biasWe;
	logic clearAll;

	// Only indices 0..14 address a weight
	assign indexValid = (cfgIndex < inputIdx'(numInputs));

	always_comb
	begin
		weightWe = 1'b0;
		biasWe = 1'b0;
		clearAll = 1'b0;
		case (cfgOp)
			cfgWeight:
			begin
				weightWe = indexValid; // Out-of-range index is dropped
			end
			cfgBias:
			begin
				biasWe = 1'b1;
			end
			cfgClear:
			begin
				clearAll = 1'b1;
			end
			default:
			begin
				clearAll = 1'b0; // cfgNone
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Per-neuron weight and bias registers
	////////////////////////////////////////////////////////////

	for (genvar n = 0; n < numNeurons; n++)
	begin : rowGen
		logic rowSel;
		actVec rowWeights;
		word rowBias;

		assign rowSel = (cfgNeuron == neuronIdx'(n));

		always_ff @(posedge clk)
		begin
			if (reset || clearAll)
			begin
				rowWeights <= '0;
			end
			else if (weightWe && rowSel)
			begin
				rowWeights[cfgIndex] <= cfgData;
			end
		end

		always_ff @(posedge clk)
		begin
			if (reset || clearAll)
			begin
				rowBias <= '0;
			end
			else if (biasWe && rowSel)
			begin
				rowBias <= cfgData;
			end
		end

		// Visible to the neurons right after the write edge
		assign weights[n] = rowWeights;
		assign biases[n] = rowBias;
	end

endmodule

// ==== nnPkg.sv ====
package nnPkg;

	////////////////////////////////////////////////////////////
	// Layer sizes
	////////////////////////////////////////////////////////////

	localparam int numInputs = 15;                        // Activations per neuron
	localparam int numNeurons = 4;                        // Neurons in the layer
	localparam int wordWidth = 16;                        // Fixed-point data width
	localparam int prodWidth = 2 * wordWidth;             // Full multiplier result

	localparam int neuronIdxWidth = $clog2(numNeurons);
	localparam int inputIdxWidth = $clog2(numInputs + 1); // Index 15 exists but addresses nothing

	////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////

	// Signed 16-bit fixed-point value
	typedef logic signed [wordWidth-1:0] word;

	// Full-width signed product, truncated back to a word in the neuron
	typedef logic signed [prodWidth-1:0] product;

	typedef word [numInputs-1:0] actVec;     // Activations, or the weights of one neuron
	typedef actVec [numNeurons-1:0] weightMat; // Weights of the whole layer
	typedef word [numNeurons-1:0] layerVec;  // Neuron outputs or biases

	typedef logic [neuronIdxWidth-1:0] neuronIdx;
	typedef logic [inputIdxWidth-1:0] inputIdx;

	////////////////////////////////////////////////////////////
	// Configuration opcodes
	////////////////////////////////////////////////////////////

	// One-cycle command from the configuration port
	typedef enum logic [1:0]
	{
		cfgNone = 2'd0,   // Idle
		cfgWeight = 2'd1, // Write one weight
		cfgBias = 2'd2,   // Write one bias
		cfgClear = 2'd3   // Zero all weights and biases
	} cfgOpT;

endpackage
